//--- hw/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
    input  wire logic             sysclk,
    input  wire logic             reset,
    input  wire logic             req_read_bus,
    input  wire logic             req_write_bus,
    input  wire logic             host_wvalid,
    output logic                  grant_read_bus,
    output logic                  grant_write_bus,
    output logic                  host_wready,
    output regbus_pkg::wr_owner_e wr_owner
);
    import regbus_pkg::*;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        PS_WRITE   = 2'd1,
        HOST_WRITE = 2'd2
    } wr_state_e;

    wr_state_e state;
    wr_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (req_write_bus)            // PS first
                    next_state = PS_WRITE;
                else if (host_wvalid)
                    next_state = HOST_WRITE;
            end
            PS_WRITE: begin
                if (!req_write_bus)           // Held for whole block write
                    next_state = IDLE;
            end
            HOST_WRITE: begin
                // Host keeps streaming unless PS asks for the bus
                if (!host_wvalid || req_write_bus)
                    next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            state          <= IDLE;
            grant_read_bus <= 1'b0;
        end else begin
            state          <= next_state;
            grant_read_bus <= req_read_bus;   // Single reader so always free
        end
    end

    assign grant_write_bus = (state == PS_WRITE);
    assign host_wready     = (state == HOST_WRITE);

    always_comb begin
        case (state)
            PS_WRITE:   wr_owner = PS;
            HOST_WRITE: wr_owner = HOST;
            default:    wr_owner = NONE;
        endcase
    end

    // Host never gets onto the write bus while PS asks for it
    a_ps_first: assert property (@(posedge sysclk) disable iff (reset)
        (req_write_bus && !host_wready) |=> !host_wready);

endmodule

`default_nettype wire

//--- hw/emio_bus.sv
`default_nettype none
`include "emio_defs.svh"

module emio_bus (
    input  wire logic                  sysclk,
    input  wire logic                  reset,
    input  wire logic [63:0]           emio_ps_out,
    input  wire logic [63:0]           emio_ps_tri,     // 1 = line is input to PS
    output logic [63:0]                emio_ps_in,
    input  wire regbus_pkg::reg_data_t reg_rdata,
    input  wire logic                  reg_rvalid,
    input  wire logic                  grant_read_bus,
    input  wire logic                  grant_write_bus,
    output logic                       req_read_bus,
    output logic                       req_write_bus,
    output regbus_pkg::reg_addr_t      reg_addr,
    output regbus_pkg::reg_data_t      reg_wdata,
    output logic                       reg_wen,
    output logic                       blk_wstart,
    output logic                       blk_wen
);
    import emio_pkg::*;
    import regbus_pkg::*;

    emio_cmd_t    cmd;
    emio_status_u status;
    reg_data_t    ps_reg_rdata;       // Captured read data
    logic         ps_write;
    logic         ps_req_rd;
    logic         ps_req_wr;
    logic [2:0]   rd_sync;            // Two sync stages plus edge history
    logic [2:0]   wr_sync;
    logic         rd_rise;
    logic         rd_fall;
    logic         wr_rise;
    logic         wr_fall;
    logic         rd_capture;
    logic         ps_read_done;
    logic         ps_write_done;
    logic         reg_wen_latched;
    logic         is_block;           // Hold write bus until req_bus falls

    // PS lines are quasi-static, used only once the bus is granted
    assign cmd        = emio_ps_out;
    assign reg_addr   = cmd.addr;
    assign reg_wdata  = cmd.wdata;
    assign reg_wen    = cmd.reg_wen;
    assign blk_wstart = cmd.blk_wstart;
    assign blk_wen    = cmd.blk_wen;

    // Write when PS drives all data lines, read otherwise
    assign ps_write  = (emio_ps_tri[31:0] == 32'd0);
    assign ps_req_rd = cmd.req_bus & ~ps_write;
    assign ps_req_wr = cmd.req_bus & ps_write;

    assign rd_rise    = rd_sync[1] & ~rd_sync[2];
    assign rd_fall    = ~rd_sync[1] & rd_sync[2];
    assign wr_rise    = wr_sync[1] & ~wr_sync[2];
    assign wr_fall    = ~wr_sync[1] & wr_sync[2];
    assign rd_capture = req_read_bus & grant_read_bus & reg_rvalid;

    // Read side
    always_ff @(posedge sysclk) begin
        if (reset) begin
            rd_sync      <= '0;
            req_read_bus <= 1'b0;
            ps_read_done <= 1'b0;
        end else begin
            rd_sync <= {rd_sync[1:0], ps_req_rd};
            if (rd_rise)
                req_read_bus <= 1'b1;
            if (rd_capture) begin
                ps_read_done <= 1'b1;
                req_read_bus <= 1'b0;   // Done with the read bus
            end
            if (rd_fall) begin          // PS dropped req_bus
                ps_read_done <= 1'b0;
                req_read_bus <= 1'b0;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (rd_capture)
            ps_reg_rdata <= reg_rdata;
    end

    // Write side
    always_ff @(posedge sysclk) begin
        if (reset) begin
            wr_sync         <= '0;
            req_write_bus   <= 1'b0;
            ps_write_done   <= 1'b0;
            reg_wen_latched <= 1'b0;
            is_block        <= 1'b0;
        end else begin
            wr_sync         <= {wr_sync[1:0], ps_req_wr};
            reg_wen_latched <= cmd.reg_wen;
            if (wr_rise) begin
                req_write_bus <= 1'b1;
                is_block      <= cmd.blk_wstart;
            end
            // Grant seen while still requesting
            if (req_write_bus && grant_write_bus) begin
                ps_write_done <= reg_wen_latched;
                req_write_bus <= is_block;
            end
            if (wr_fall) begin
                ps_write_done <= 1'b0;
                req_write_bus <= 1'b0;  // Ends a block write too
            end
        end
    end

    // Same word, two decodes
    always_comb begin
        status = '0;
        if (ps_write) begin
            status.wr.version  = `EMIO_VERSION;
            status.wr.grant    = grant_write_bus;
            status.wr.is_write = 1'b1;
            status.wr.wflags   = {cmd.blk_wen, cmd.blk_wstart, cmd.reg_wen};
            status.wr.wr_done  = ps_write_done;
            status.wr.req_bus  = cmd.req_bus;
            status.wr.addr     = cmd.addr;
            status.wr.wdata    = cmd.wdata;
        end else begin
            status.rd.version  = `EMIO_VERSION;
            status.rd.grant    = grant_read_bus;
            status.rd.is_write = 1'b0;
            status.rd.wflags   = {cmd.blk_wen, cmd.blk_wstart, cmd.reg_wen};
            status.rd.rd_done  = ps_read_done;
            status.rd.req_bus  = cmd.req_bus;
            status.rd.addr     = cmd.addr;
            status.rd.rdata    = ps_reg_rdata;
        end
    end

    assign emio_ps_in = status;

    // PS can only be in one transaction at a time
    a_one_request: assert property (@(posedge sysclk) disable iff (reset)
        !(req_read_bus && req_write_bus));

endmodule

`default_nettype wire

//--- hw/emio_defs.svh
`ifndef EMIO_DEFS_SVH
`define EMIO_DEFS_SVH

// Version nibble reported in status bits 63:60
`define EMIO_VERSION 4'h1

// Register bus widths
`define REG_ADDR_W 16
`define REG_DATA_W 32

// Implemented registers, selected by the low address bits only
`define REG_COUNT 64

// Cycles from read grant to read data valid
`define READ_LATENCY 3

`endif

//--- hw/emio_pkg.sv
`default_nettype none
`include "emio_defs.svh"

package emio_pkg;

    // PS output word, driven by the processor
    typedef struct packed {
        logic [10:0]             unused_hi;   // 63:53
        logic                    blk_wen;     // Block write strobe
        logic                    blk_wstart;  // Block write start
        logic                    reg_wen;     // Single write enable
        logic                    unused_49;
        logic                    req_bus;     // Bus request level
        logic [`REG_ADDR_W-1:0]  addr;
        logic [`REG_DATA_W-1:0]  wdata;
    } emio_cmd_t;

    // Status word seen by PS during a read
    typedef struct packed {
        logic [3:0]              version;
        logic [4:0]              zero;
        logic                    grant;
        logic                    is_write;    // 0 here
        logic [2:0]              wflags;      // blk_wen, blk_wstart, reg_wen
        logic                    rd_done;     // Read data captured
        logic                    req_bus;
        logic [`REG_ADDR_W-1:0]  addr;
        logic [`REG_DATA_W-1:0]  rdata;       // Register contents
    } emio_rd_status_t;

    // Same layout, write meaning
    typedef struct packed {
        logic [3:0]              version;
        logic [4:0]              zero;
        logic                    grant;
        logic                    is_write;    // 1 here
        logic [2:0]              wflags;
        logic                    wr_done;     // Write bus seen, carries reg_wen
        logic                    req_bus;
        logic [`REG_ADDR_W-1:0]  addr;
        logic [`REG_DATA_W-1:0]  wdata;       // Echo of PS write data
    } emio_wr_status_t;

    typedef union packed {
        emio_rd_status_t rd;
        emio_wr_status_t wr;
    } emio_status_u;

endpackage

`default_nettype wire

//--- hw/emio_subsys_top.sv
`default_nettype none

module emio_subsys_top (
    input  wire logic                  sysclk,
    input  wire logic                  reset,
    input  wire logic [63:0]           emio_ps_out,
    input  wire logic [63:0]           emio_ps_tri,
    output logic [63:0]                emio_ps_in,
    input  wire logic                  host_wvalid,
    input  wire regbus_pkg::reg_addr_t host_waddr,
    input  wire regbus_pkg::reg_data_t host_wdata,
    output logic                       host_wready
);
    import regbus_pkg::*;

    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    reg_data_t reg_rdata;
    wr_owner_e wr_owner;
    logic      reg_wen;
    logic      blk_wstart;
    logic      blk_wen;
    logic      reg_rvalid;
    logic      req_read_bus;
    logic      req_write_bus;
    logic      grant_read_bus;
    logic      grant_write_bus;

    emio_bus u_emio_bus (
        .sysclk(sysclk), .reset(reset),
        .emio_ps_out(emio_ps_out), .emio_ps_tri(emio_ps_tri), .emio_ps_in(emio_ps_in),
        .reg_rdata(reg_rdata), .reg_rvalid(reg_rvalid),
        .grant_read_bus(grant_read_bus), .grant_write_bus(grant_write_bus),
        .req_read_bus(req_read_bus), .req_write_bus(req_write_bus),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_wen(reg_wen),
        .blk_wstart(blk_wstart), .blk_wen(blk_wen)
    );

    bus_arbiter u_bus_arbiter (
        .sysclk(sysclk), .reset(reset),
        .req_read_bus(req_read_bus), .req_write_bus(req_write_bus),
        .host_wvalid(host_wvalid),
        .grant_read_bus(grant_read_bus), .grant_write_bus(grant_write_bus),
        .host_wready(host_wready), .wr_owner(wr_owner)
    );

    read_latency_timer u_read_latency_timer (
        .sysclk(sysclk), .reset(reset),
        .grant_read_bus(grant_read_bus), .reg_rvalid(reg_rvalid)
    );

    reg_file u_reg_file (
        .sysclk(sysclk), .reset(reset), .wr_owner(wr_owner),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_wen(reg_wen),
        .blk_wstart(blk_wstart), .blk_wen(blk_wen),
        .host_waddr(host_waddr), .host_wdata(host_wdata),
        .host_wvalid(host_wvalid), .host_wready(host_wready),
        .reg_rdata(reg_rdata)
    );

endmodule

`default_nettype wire

//--- hw/read_latency_timer.sv
`default_nettype none
`include "emio_defs.svh"

module read_latency_timer (
    input  wire logic sysclk,
    input  wire logic reset,
    input  wire logic grant_read_bus,
    output logic      reg_rvalid
);
    localparam int CNT_W = $clog2(`READ_LATENCY + 1);

    logic [CNT_W-1:0] cnt;   // Cycles since grant

    // Counter idles at zero while no grant, so it restarts on each grant
    always_ff @(posedge sysclk) begin
        if (reset || !grant_read_bus) begin
            cnt        <= '0;
            reg_rvalid <= 1'b0;
        end else if (!reg_rvalid) begin
            cnt <= cnt + 1'b1;
            if (cnt == CNT_W'(`READ_LATENCY - 1))
                reg_rvalid <= 1'b1;   // Holds until grant drops
        end
    end

    // Uninterrupted grant must produce valid on time
    a_latency: assert property (@(posedge sysclk) disable iff (reset)
        $rose(grant_read_bus) ##1 grant_read_bus [* (`READ_LATENCY - 1)]
        |=> reg_rvalid);

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`default_nettype none
`include "emio_defs.svh"

module reg_file (
    input  wire logic                  sysclk,
    input  wire logic                  reset,
    input  var  regbus_pkg::wr_owner_e wr_owner,
    input  wire regbus_pkg::reg_addr_t reg_addr,
    input  wire regbus_pkg::reg_data_t reg_wdata,
    input  wire logic                  reg_wen,
    input  wire logic                  blk_wstart,
    input  wire logic                  blk_wen,
    input  wire regbus_pkg::reg_addr_t host_waddr,
    input  wire regbus_pkg::reg_data_t host_wdata,
    input  wire logic                  host_wvalid,
    input  wire logic                  host_wready,
    output regbus_pkg::reg_data_t      reg_rdata
);
    import regbus_pkg::*;

    localparam int IDX_W = $clog2(`REG_COUNT);

    reg_data_t        regs [`REG_COUNT];
    logic [IDX_W-1:0] blk_ptr;      // Next block word
    logic             blk_wen_q;
    logic             ps_owner;
    logic             ps_single;
    logic             ps_blk;
    logic             host_xfer;
    logic             wr_en;
    logic [IDX_W-1:0] wr_idx;
    reg_data_t        wr_data;

    assign ps_owner  = (wr_owner == PS);
    assign ps_single = ps_owner & reg_wen & ~blk_wstart;
    assign ps_blk    = ps_owner & blk_wstart & blk_wen & ~blk_wen_q;   // Strobe edge
    assign host_xfer = (wr_owner == HOST) & host_wvalid & host_wready;
    assign wr_en     = ps_single | ps_blk | host_xfer;

    // Source mux by owner
    always_comb begin
        if (wr_owner == HOST) begin
            wr_idx  = host_waddr[IDX_W-1:0];
            wr_data = host_wdata;
        end else begin
            wr_idx  = blk_wstart ? blk_ptr : reg_addr[IDX_W-1:0];
            wr_data = reg_wdata;
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
            blk_ptr   <= '0;
            blk_wen_q <= 1'b0;
        end else begin
            blk_wen_q <= blk_wen;
            if (blk_wstart && !ps_owner)
                blk_ptr <= reg_addr[IDX_W-1:0];   // Base address, until granted
            else if (ps_blk)
                blk_ptr <= blk_ptr + 1'b1;
            if (wr_en)
                regs[wr_idx] <= wr_data;
        end
    end

    always_ff @(posedge sysclk) begin
        reg_rdata <= regs[reg_addr[IDX_W-1:0]];
    end

endmodule

`default_nettype wire

//--- hw/regbus_pkg.sv
`default_nettype none
`include "emio_defs.svh"

package regbus_pkg;

    // Register bus address and data
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`REG_DATA_W-1:0] reg_data_t;

    // Who currently drives the write bus
    typedef enum logic [1:0] {
        NONE = 2'd0,   // Bus idle
        PS   = 2'd1,   // Processor via EMIO
        HOST = 2'd2    // Host write port
    } wr_owner_e;

endpackage

`default_nettype wire

//--- sim/emio_tb.sv
`default_nettype none
`include "emio_defs.svh"

module emio_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import emio_pkg::*;
    import regbus_pkg::*;

    localparam int NUM_TXN    = 220;    // Rough count of transactions issued below
    localparam int CLK_PERIOD = 20;
    localparam int WAIT_MAX   = 200;    // Cycles allowed per handshake
    localparam int IDX_W      = $clog2(`REG_COUNT);

    logic             sysclk;
    logic             reset;
    emio_cmd_t        cmd;              // PS output word
    logic [63:0]      ps_tri;           // All zero means write
    logic [63:0]      emio_ps_in;
    logic             host_wvalid;
    reg_addr_t        host_waddr;
    reg_data_t        host_wdata;
    logic             host_wready;

    reg_data_t        model [`REG_COUNT];
    logic [IDX_W-1:0] blk_idx;          // Model copy of the block pointer
    reg_data_t        rd_got_q[$];
    reg_data_t        rd_exp_q[$];
    string            rd_msg_q[$];
    emio_status_u     st_got_q[$];
    emio_status_u     st_exp_q[$];
    emio_status_u     st_mask_q[$];
    string            st_msg_q[$];
    int               data_errors;
    int               status_errors;
    int               proto_errors;

    emio_subsys_top uut (
        .sysclk(sysclk), .reset(reset),
        .emio_ps_out(cmd), .emio_ps_tri(ps_tri), .emio_ps_in(emio_ps_in),
        .host_wvalid(host_wvalid), .host_waddr(host_waddr), .host_wdata(host_wdata),
        .host_wready(host_wready)
    );

    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    // Low address bits pick the register and unwritten ones read zero
    function automatic reg_data_t expected_reg(reg_addr_t addr);
        return model[addr[IDX_W-1:0]];
    endfunction

    function automatic logic done_of(emio_status_u st);
        if (st.wr.is_write)
            return st.wr.wr_done;
        return st.rd.rd_done;
    endfunction

    function automatic emio_status_u field_mask(logic with_data, logic with_grant);
        emio_status_u m;
        m            = '0;
        m.rd.version = '1;
        m.rd.zero    = '1;
        m.rd.rd_done = 1'b1;
        m.rd.grant   = with_grant;
        if (!with_grant) begin          // Transaction view leaves grant timing open
            m.rd.is_write = 1'b1;
            m.rd.wflags   = '1;
            m.rd.req_bus  = 1'b1;
            m.rd.addr     = '1;
        end
        if (with_data)
            m.rd.rdata = '1;
        return m;
    endfunction

    function automatic emio_status_u write_status(reg_addr_t addr, reg_data_t data,
                                                  logic [2:0] flags);
        emio_status_u s;
        s             = '0;
        s.wr.version  = `EMIO_VERSION;
        s.wr.is_write = 1'b1;
        s.wr.wflags   = flags;         // blk_wen, blk_wstart, reg_wen as driven
        s.wr.wr_done  = 1'b1;
        s.wr.req_bus  = 1'b1;
        s.wr.addr     = addr;
        s.wr.wdata    = data;          // Echo of PS data
        return s;
    endfunction

    task automatic compare_data(reg_data_t got, reg_data_t exp, string what);
        if (got !== exp) begin
            data_errors++;
            $display("ERR @%0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic compare_status(emio_status_u got, emio_status_u exp, emio_status_u mask,
                                  string what);
        if ((got & mask) !== (exp & mask)) begin
            status_errors++;
            $display("ERR @%0t: %s status 0x%016h, expected 0x%016h, mask 0x%016h",
                     $time, what, got, exp, mask);
        end
    endtask

    task automatic expect_read(reg_addr_t addr, reg_data_t got, string what);
        rd_got_q.push_back(got);
        rd_exp_q.push_back(expected_reg(addr));   // Model as of this read
        rd_msg_q.push_back(what);
    endtask

    task automatic expect_status(emio_status_u got, emio_status_u exp, emio_status_u mask,
                                 string what);
        st_got_q.push_back(got);
        st_exp_q.push_back(exp);
        st_mask_q.push_back(mask);
        st_msg_q.push_back(what);
    endtask

    // Drains on rising edges while pushes happen on falling edges
    always @(posedge sysclk) begin
        while (rd_got_q.size() > 0)
            compare_data(rd_got_q.pop_front(), rd_exp_q.pop_front(), rd_msg_q.pop_front());
        while (st_got_q.size() > 0)
            compare_status(st_got_q.pop_front(), st_exp_q.pop_front(),
                           st_mask_q.pop_front(), st_msg_q.pop_front());
    end

    // Poll status on falling edges where idle also wants the grant gone
    task automatic wait_status(input logic done_level, input logic idle, input string what);
        emio_status_u st;
        int           n;
        for (n = 0; n < WAIT_MAX; n++) begin
            @(negedge sysclk);
            st = emio_ps_in;
            if (done_of(st) === done_level && (!idle || st.wr.grant === 1'b0))
                return;
        end
        proto_errors++;
        $display("Timeout: %s never saw done at %0b", what, done_level);
    endtask

    task automatic ps_read(input reg_addr_t addr, input string what);
        emio_status_u st;
        emio_status_u exp;
        @(negedge sysclk);
        ps_tri      = '1;               // Data lines into PS
        cmd         = '0;
        cmd.addr    = addr;
        cmd.req_bus = 1'b1;
        wait_status(1'b1, 1'b0, what);
        st             = emio_ps_in;
        exp            = '0;
        exp.rd.version = `EMIO_VERSION;
        exp.rd.rd_done = 1'b1;
        exp.rd.req_bus = 1'b1;
        exp.rd.addr    = addr;
        expect_status(st, exp, field_mask(1'b0, 1'b0), what);
        expect_read(addr, st.rd.rdata, what);
        cmd.req_bus = 1'b0;
        wait_status(1'b0, 1'b1, what);  // Done must clear after req_bus falls
        cmd = '0;
    endtask

    task automatic ps_write(input reg_addr_t addr, input reg_data_t data, input string what);
        @(negedge sysclk);
        ps_tri      = '0;
        cmd         = '0;
        cmd.addr    = addr;
        cmd.wdata   = data;
        cmd.reg_wen = 1'b1;
        cmd.req_bus = 1'b1;
        wait_status(1'b1, 1'b0, what);
        model[addr[IDX_W-1:0]] = data;
        expect_status(emio_ps_in, write_status(addr, data, 3'b001),
                      field_mask(1'b1, 1'b0), what);
        cmd.req_bus = 1'b0;
        wait_status(1'b0, 1'b1, what);
        cmd    = '0;
        ps_tri = '1;
    endtask

    task automatic block_open(input reg_addr_t base, input string what);
        @(negedge sysclk);
        ps_tri         = '0;
        cmd            = '0;
        cmd.addr       = base;
        cmd.blk_wstart = 1'b1;
        cmd.reg_wen    = 1'b1;          // So done reports the grant
        cmd.req_bus    = 1'b1;
        blk_idx        = base[IDX_W-1:0];
        wait_status(1'b1, 1'b0, what);
        expect_status(emio_ps_in, write_status(base, '0, 3'b011),
                      field_mask(1'b1, 1'b0), what);
    endtask

    // One blk_wen pulse then low for a full cycle
    task automatic block_word(input reg_data_t data);
        @(negedge sysclk);
        cmd.wdata   = data;
        cmd.blk_wen = 1'b1;
        @(negedge sysclk);
        cmd.blk_wen    = 1'b0;
        model[blk_idx] = data;
        blk_idx        = blk_idx + 1'b1;
    endtask

    task automatic block_close(input string what);
        @(negedge sysclk);
        cmd.req_bus = 1'b0;             // Flags stay until the bus is released
        wait_status(1'b0, 1'b1, what);
        cmd    = '0;
        ps_tri = '1;
    endtask

    task automatic host_start(input reg_addr_t addr, input reg_data_t data);
        @(negedge sysclk);
        host_wvalid = 1'b1;
        host_waddr  = addr;
        host_wdata  = data;
    endtask

    task automatic host_finish(input string what);
        int n;
        n = 0;
        while (!host_wready && n < WAIT_MAX) begin
            @(negedge sysclk);
            n++;
        end
        if (!host_wready) begin
            proto_errors++;
            $display("Timeout: %s to 0x%04h was never accepted", what, host_waddr);
        end else begin
            model[host_waddr[IDX_W-1:0]] = host_wdata;
        end
        @(negedge sysclk);              // Transfer on the edge in between
        host_wvalid = 1'b0;
    endtask

    initial begin
        #(NUM_TXN * 100 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, run stopped", NUM_TXN * 100);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int           i;
        int           kind;
        emio_status_u idle;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(31387));
        sysclk        = 1'b0;
        reset         = 1'b1;
        cmd           = '0;
        ps_tri        = '1;
        host_wvalid   = 1'b0;
        host_waddr    = '0;
        host_wdata    = '0;
        data_errors   = 0;
        status_errors = 0;
        proto_errors  = 0;
        blk_idx       = '0;
        for (i = 0; i < `REG_COUNT; i++)
            model[i] = '0;
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b0;

        // Idle status word
        @(negedge sysclk);
        idle            = '0;
        idle.rd.version = `EMIO_VERSION;
        expect_status(emio_ps_in, idle, field_mask(1'b0, 1'b1), "after reset");

        ps_write(16'h0123, 32'hcafe_0001, "single write");
        ps_read(16'h0123, "single read back");

        // Eight word block from 0x14
        block_open(16'h0014, "block open");
        for (i = 0; i < 8; i++)
            block_word($urandom);
        block_close("block close");
        for (i = 0; i < 8; i++)
            ps_read(reg_addr_t'(16'h0014 + i), $sformatf("block read %0d", i));

        // Host blocked while PS holds the write bus
        block_open(16'h0030, "contended block open");
        host_start(16'h0005, 32'h5a5a_0004);
        for (i = 0; i < 4; i++) begin
            block_word($urandom);
            if (host_wready) begin
                proto_errors++;
                $display("Host write accepted at %0t while PS held the write bus", $time);
            end
        end
        block_close("contended block close");
        host_finish("host write after block");
        ps_read(16'h0005, "host data read");
        ps_read(16'h0031, "contended block read");

        // Mixed traffic where full 16 bit addresses alias onto 64 registers
        for (i = 0; i < 200; i++) begin
            kind = $urandom_range(0, 2);
            if (kind == 0) begin
                ps_read(reg_addr_t'($urandom), $sformatf("random read %0d", i));
            end else if (kind == 1) begin
                ps_write(reg_addr_t'($urandom), $urandom, $sformatf("random write %0d", i));
            end else begin
                host_start(reg_addr_t'($urandom), $urandom);
                host_finish($sformatf("random host write %0d", i));
            end
        end

        repeat (3) @(negedge sysclk);   // Let the compare process drain
        $display("Errors: data %0d, status %0d, protocol %0d",
                 data_errors, status_errors, proto_errors);
        if (data_errors + status_errors + proto_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+hw
hw/emio_pkg.sv
hw/regbus_pkg.sv
hw/emio_bus.sv
hw/bus_arbiter.sv
hw/read_latency_timer.sv
hw/reg_file.sv
hw/emio_subsys_top.sv
sim/emio_tb.sv
